/* hdl/sram_ctrl_config.svh */
// Project-wide sizing macros for the channel buffer controller, included wherever a size is needed
`ifndef SRAM_CTRL_CONFIG_SVH
`define SRAM_CTRL_CONFIG_SVH

// ============================================================
// Channel and storage geometry
// ============================================================

// Number of independent channels
`define SRAM_NUM_CHANNELS 4

// Bits per data beat
`define SRAM_DATA_WIDTH 32

// Words per channel FIFO, bridge word not included
`define SRAM_DEPTH 16

// Channel ID width
// Wider than needed so IDs above the channel count are out of range
`define SRAM_CHAN_ID_WIDTH 3

`endif

/* hdl/sram_ctrl_pkg.sv */
// Shared data types for the channel buffer controller, imported by every module that uses them
`default_nettype none

`include "sram_ctrl_config.svh"

package sram_ctrl_pkg;

        // ============================================================
        // Bus and bookkeeping types
        // ============================================================

        // One data beat on the shared write and read buses
        typedef logic [`SRAM_DATA_WIDTH-1:0] word_t;

        // Channel select on the shared buses
        typedef logic [`SRAM_CHAN_ID_WIDTH-1:0] chan_id_t;

        // Word count, 0 through depth inclusive
        typedef logic [$clog2(`SRAM_DEPTH):0] count_t;

        // Burst size carried by an allocation or drain reservation
        typedef logic [7:0] size_t;

endpackage : sram_ctrl_pkg

`default_nettype wire

/* hdl/chan_port_if.sv */
// Per-channel link between the ID decode, the channel unit and its latency bridge
`timescale 1ns/1ps
`default_nettype none

interface chan_port_if
        import sram_ctrl_pkg::*;
();

        // Strobes from the decode, already steered to this channel
        logic  wr_strobe;       // Write beat offered
        logic  pop_strobe;      // Consumer pops the head
        logic  alloc_strobe;    // Allocation reservation request

        // Storage side
        logic  wr_ready;        // FIFO not full
        logic  fifo_rd_en;      // Move storage head into the bridge
        word_t fifo_data;       // Storage head word

        // Bridge side
        logic  rd_valid;        // Bridge holds a word
        word_t rd_data;         // Word held in the bridge

        modport decode (
                output wr_strobe, pop_strobe, alloc_strobe,
                input  wr_ready, rd_data
        );

        modport unit (
                input  wr_strobe, pop_strobe, alloc_strobe, rd_valid,
                output wr_ready, fifo_rd_en, fifo_data
        );

        modport bridge (
                input  pop_strobe, fifo_rd_en, fifo_data,
                output rd_valid, rd_data
        );

endinterface : chan_port_if

`default_nettype wire

/* hdl/chan_id_decode.sv */
// Steers the shared ID-addressed buses onto per-channel strobes and muxes ready and data back
`timescale 1ns/1ps
`default_nettype none

`include "sram_ctrl_config.svh"

module chan_id_decode
        import sram_ctrl_pkg::*;
(
        input  logic        alloc_req,      // Allocation request
        input  chan_id_t    alloc_id,       // Channel for the allocation
        input  logic        wr_valid,       // Shared write valid
        input  chan_id_t    wr_id,          // Channel for the write beat
        input  logic        rd_pop,         // Shared pop request
        input  chan_id_t    rd_id,          // Channel for read data and pop
        output logic        wr_ready,       // Ready of the addressed channel
        output word_t       rd_data,        // Head of the addressed channel
        chan_port_if.decode chans [`SRAM_NUM_CHANNELS]
);

        localparam int SEL_W = $clog2(`SRAM_NUM_CHANNELS);

        logic  [`SRAM_NUM_CHANNELS-1:0] ready_vec;  // Gathered per-channel ready
        word_t                          data_vec [`SRAM_NUM_CHANNELS];
        logic                           wr_id_ok;
        logic                           rd_id_ok;

        // IDs at or above the channel count select nothing
        assign wr_id_ok = wr_id < chan_id_t'(`SRAM_NUM_CHANNELS);
        assign rd_id_ok = rd_id < chan_id_t'(`SRAM_NUM_CHANNELS);

        // ============================================================
        // One-hot strobes per channel
        // ============================================================

        for (genvar i = 0; i < `SRAM_NUM_CHANNELS; i++) begin : gen_chan
                // Full-width compare, so IDs out of range never match
                assign chans[i].wr_strobe    = wr_valid && (wr_id == chan_id_t'(i));
                assign chans[i].pop_strobe   = rd_pop && (rd_id == chan_id_t'(i));
                assign chans[i].alloc_strobe = alloc_req && (alloc_id == chan_id_t'(i));

                // Ready and head data gathered for the return muxes
                assign ready_vec[i] = chans[i].wr_ready;
                assign data_vec[i]  = chans[i].rd_data;
        end

        // ============================================================
        // Return muxes onto the shared buses
        // ============================================================

        always_comb begin
                if (wr_id_ok) begin
                        wr_ready = ready_vec[wr_id[SEL_W-1:0]];
                end else begin
                        wr_ready = 1'b0;        // Nobody home
                end
        end

        always_comb begin
                if (rd_id_ok) begin
                        rd_data = data_vec[rd_id[SEL_W-1:0]];
                end else begin
                        rd_data = '0;
                end
        end

endmodule : chan_id_decode

`default_nettype wire

/* hdl/sram_channel_unit.sv */
// One channel's FIFO storage with allocation and drain reservation bookkeeping, one per channel
`timescale 1ns/1ps
`default_nettype none

`include "sram_ctrl_config.svh"

module sram_channel_unit
        import sram_ctrl_pkg::*;
(
        input  logic     clk,
        input  logic     arst_n,
        input  word_t    wr_data,       // Shared write data
        input  size_t    alloc_size,    // Shared allocation size
        input  logic     drain_req,     // Drain reservation request
        input  size_t    drain_size,    // Beats to reserve for draining
        output count_t   space_free,    // Depth less reservations and occupancy
        output count_t   data_avail,    // Occupancy less drain reservations
        chan_port_if.unit port
);

        localparam int PTR_W = $clog2(`SRAM_DEPTH);
        localparam int RES_W = 12;      // Room for many stacked bursts

        word_t            mem [`SRAM_DEPTH];   // Circular storage
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        count_t           stored;              // Words in storage, bridge excluded
        logic             push;
        logic             pop;
        logic             pull;
        logic [RES_W-1:0] alloc_res;           // Outstanding write reservations
        logic [RES_W-1:0] drain_res;           // Outstanding pop reservations
        logic [RES_W-1:0] alloc_sum;
        logic [RES_W-1:0] drain_sum;
        logic [RES_W-1:0] occupancy;
        logic [RES_W-1:0] alloc_used;

        // ============================================================
        // FIFO storage
        // ============================================================

        assign push = port.wr_strobe && port.wr_ready;     // Beat accepted
        assign pop  = port.pop_strobe && port.rd_valid;    // Head consumed
        assign pull = port.fifo_rd_en;

        assign port.wr_ready = stored != count_t'(`SRAM_DEPTH);

        // Refill only an empty bridge, which leaves a bubble after each pop
        assign port.fifo_rd_en = !port.rd_valid && (stored != '0);

        assign port.fifo_data = mem[rd_ptr];    // Read path is combinational

        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        stored <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
                        end
                        if (pull) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({push, pull})
                                2'b10:   stored <= stored + 1'b1;
                                2'b01:   stored <= stored - 1'b1;
                                default: stored <= stored;     // Both or neither
                        endcase
                end
        end

        // ============================================================
        // Reservation counters
        // ============================================================

        // New reservation lands first, then the beat retires one
        assign alloc_sum = alloc_res + (port.alloc_strobe ? RES_W'(alloc_size) : '0);
        assign drain_sum = drain_res + (drain_req ? RES_W'(drain_size) : '0);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        alloc_res <= '0;
                        drain_res <= '0;
                end else begin
                        alloc_res <= (push && alloc_sum != '0) ? alloc_sum - 1'b1 : alloc_sum;
                        drain_res <= (pop && drain_sum != '0) ? drain_sum - 1'b1 : drain_sum;
                end
        end

        // ============================================================
        // Credit outputs
        // ============================================================

        // Bridge word still counts, so a storage-to-bridge move is neutral
        assign occupancy  = RES_W'(stored) + RES_W'(port.rd_valid);
        assign alloc_used = alloc_res + occupancy;

        always_comb begin
                if (alloc_used >= RES_W'(`SRAM_DEPTH)) begin
                        space_free = '0;        // Clamp
                end else begin
                        space_free = count_t'(RES_W'(`SRAM_DEPTH) - alloc_used);
                end
        end

        always_comb begin
                if (occupancy > drain_res) begin
                        data_avail = count_t'(occupancy - drain_res);
                end else begin
                        data_avail = '0;
                end
        end

endmodule : sram_channel_unit

`default_nettype wire

/* hdl/chan_latency_bridge.sv */
// Registered output stage that holds a channel's head word and flags it valid for the consumer
`timescale 1ns/1ps
`default_nettype none

module chan_latency_bridge
        import sram_ctrl_pkg::*;
(
        input  logic clk,
        input  logic arst_n,
        chan_port_if.bridge port
);

        word_t head_q;          // Head word presented to the read bus
        logic  valid_q;         // Head word present
        logic  pop;             // Pop that actually consumes a word

        // ============================================================
        // Valid tracking
        // ============================================================

        // Popping an empty bridge does nothing
        assign pop = port.pop_strobe && valid_q;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        valid_q <= 1'b0;
                end else if (port.fifo_rd_en) begin
                        valid_q <= 1'b1;        // Load only while empty
                end else if (pop) begin
                        valid_q <= 1'b0;
                end
        end

        // ============================================================
        // Head register
        // ============================================================

        // Captures the storage head on the edge the unit pulls it
        always_ff @(posedge clk) begin
                if (port.fifo_rd_en) begin
                        head_q <= port.fifo_data;
                end
        end

        // Presence also feeds the unit's occupancy count
        assign port.rd_valid = valid_q;
        assign port.rd_data  = head_q;

endmodule : chan_latency_bridge

`default_nettype wire

/* hdl/sram_controller.sv */
// Top level of the four-channel buffer controller, joining decode, channel units and bridges
`timescale 1ns/1ps
`default_nettype none

`include "sram_ctrl_config.svh"

module sram_controller
        import sram_ctrl_pkg::*;
(
        input  logic                                 clk,
        input  logic                                 arst_n,

        // ============================================================
        // Allocation credits, filling side
        // ============================================================
        input  logic                                 alloc_req,
        input  size_t                                alloc_size,
        input  chan_id_t                             alloc_id,
        output count_t [`SRAM_NUM_CHANNELS-1:0]      space_free,

        // Shared write bus
        input  logic                                 wr_valid,
        output logic                                 wr_ready,
        input  chan_id_t                             wr_id,
        input  word_t                                wr_data,

        // ============================================================
        // Drain credits, emptying side
        // ============================================================
        input  logic   [`SRAM_NUM_CHANNELS-1:0]      drain_req,
        input  size_t  [`SRAM_NUM_CHANNELS-1:0]      drain_size,
        output count_t [`SRAM_NUM_CHANNELS-1:0]      data_avail,

        // Shared read bus
        output logic   [`SRAM_NUM_CHANNELS-1:0]      rd_valid,
        input  logic                                 rd_pop,
        input  chan_id_t                             rd_id,
        output word_t                                rd_data
);

        chan_port_if chans [`SRAM_NUM_CHANNELS] ();

        // ID checks happen here and nowhere else
        chan_id_decode u_decode (
                .alloc_req (alloc_req),
                .alloc_id  (alloc_id),
                .wr_valid  (wr_valid),
                .wr_id     (wr_id),
                .rd_pop    (rd_pop),
                .rd_id     (rd_id),
                .wr_ready  (wr_ready),
                .rd_data   (rd_data),
                .chans     (chans)
        );

        for (genvar i = 0; i < `SRAM_NUM_CHANNELS; i++) begin : gen_chan
                sram_channel_unit u_unit (
                        .clk        (clk),
                        .arst_n     (arst_n),
                        .wr_data    (wr_data),          // Shared by all units
                        .alloc_size (alloc_size),       // Shared by all units
                        .drain_req  (drain_req[i]),
                        .drain_size (drain_size[i]),
                        .space_free (space_free[i]),
                        .data_avail (data_avail[i]),
                        .port       (chans[i])
                );

                chan_latency_bridge u_bridge (
                        .clk    (clk),
                        .arst_n (arst_n),
                        .port   (chans[i])
                );

                assign rd_valid[i] = chans[i].rd_valid;
        end

endmodule : sram_controller

`default_nettype wire

/* tb/tb_sram_controller.sv */
// Self-checking testbench for the buffer controller, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

`include "sram_ctrl_config.svh"

module tb_sram_controller
        import sram_ctrl_pkg::*;
();

        localparam int NCH            = `SRAM_NUM_CHANNELS;
        localparam int TIMEOUT_CYCLES = 200;   // Per wait loop
        localparam int RANDOM_CYCLES  = 800;

        logic                   clk;
        logic                   arst_n;
        logic                   alloc_req;
        size_t                  alloc_size;
        chan_id_t               alloc_id;
        count_t [NCH-1:0]       space_free;
        logic                   wr_valid;
        logic                   wr_ready;
        chan_id_t               wr_id;
        word_t                  wr_data;
        logic   [NCH-1:0]       drain_req;
        size_t  [NCH-1:0]       drain_size;
        count_t [NCH-1:0]       data_avail;
        logic   [NCH-1:0]       rd_valid;
        logic                   rd_pop;
        chan_id_t               rd_id;
        word_t                  rd_data;

        // Reference model, one entry per channel
        word_t       model_q [NCH][$];          // Words in storage plus bridge, oldest first
        int          model_bvalid [NCH];        // Bridge holds a word
        int          alloc_res [NCH];
        int          drain_res [NCH];
        logic        checking = 1'b0;
        logic [31:0] lcg_state = 32'd1;         // Seed

        sram_controller u_dut (
                .clk (clk), .arst_n (arst_n),
                .alloc_req (alloc_req), .alloc_size (alloc_size), .alloc_id (alloc_id),
                .space_free (space_free),
                .wr_valid (wr_valid), .wr_ready (wr_ready), .wr_id (wr_id), .wr_data (wr_data),
                .drain_req (drain_req), .drain_size (drain_size), .data_avail (data_avail),
                .rd_valid (rd_valid), .rd_pop (rd_pop), .rd_id (rd_id), .rd_data (rd_data)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;         // 100 ns period
        end

        // ============================================================
        // Random numbers and failure reporting
        // ============================================================

        function automatic logic [31:0] rand_next();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        function automatic int rand_below(input int n);
                return int'(rand_next() >> 16) % n;     // Upper bits are less periodic
        endfunction

        // Mostly a valid channel, one time in eight an out-of-range ID
        function automatic chan_id_t random_id();
                if (rand_below(8) < 7) begin
                        return chan_id_t'(rand_below(NCH));
                end
                return chan_id_t'(4 + rand_below(4));
        endfunction

        task automatic abort_run();
                $display("Some tests failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic report_failure(input string msg);
                $display("ERROR at %0t ns: %s", $time, msg);
                abort_run();
        endtask

        task automatic check_word(input string name, input word_t got, input word_t exp);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %h expected %h",
                                 $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_count(input string name, input count_t got, input count_t exp);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %0d expected %0d",
                                 $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %b expected %b",
                                 $time, name, got, exp);
                        abort_run();
                end
        endtask

        // ============================================================
        // Reference model
        // ============================================================

        function automatic int model_stored(input int c);
                return model_q[c].size() - model_bvalid[c];     // Bridge word excluded
        endfunction

        // Depth less reservations and occupancy, floored at zero
        function automatic count_t expected_space(input int c);
                int free;
                free = `SRAM_DEPTH - alloc_res[c] - model_q[c].size();
                if (free < 0) free = 0;
                return count_t'(free);
        endfunction

        // Occupancy less drain reservations, floored at zero
        function automatic count_t expected_avail(input int c);
                int avail;
                avail = model_q[c].size() - drain_res[c];
                if (avail < 0) avail = 0;
                return count_t'(avail);
        endfunction

        // Applies one clock edge using the inputs held since the last falling edge
        task automatic advance_model();
                logic push;
                logic pop;
                logic pull;
                int   sum;
                for (int c = 0; c < NCH; c++) begin
                        push = wr_valid && (wr_id == chan_id_t'(c)) &&
                               (model_stored(c) != `SRAM_DEPTH);
                        pop  = rd_pop && (rd_id == chan_id_t'(c)) && (model_bvalid[c] != 0);
                        pull = (model_bvalid[c] == 0) && (model_stored(c) > 0);
                        sum  = alloc_res[c];
                        if (alloc_req && alloc_id == chan_id_t'(c)) sum += int'(alloc_size);
                        alloc_res[c] = (push && sum > 0) ? sum - 1 : sum;
                        sum = drain_res[c];
                        if (drain_req[c]) sum += int'(drain_size[c]);
                        drain_res[c] = (pop && sum > 0) ? sum - 1 : sum;
                        if (pop) void'(model_q[c].pop_front());
                        if (push) model_q[c].push_back(wr_data);
                        if (pull) model_bvalid[c] = 1;
                        else if (pop) model_bvalid[c] = 0;
                end
        endtask

        task automatic compare_outputs();
                int   wid;
                int   rid;
                logic exp_ready;
                for (int c = 0; c < NCH; c++) begin
                        check_count($sformatf("space_free[%0d]", c), space_free[c],
                                    expected_space(c));
                        check_count($sformatf("data_avail[%0d]", c), data_avail[c],
                                    expected_avail(c));
                        check_flag($sformatf("rd_valid[%0d]", c), rd_valid[c],
                                   model_bvalid[c] != 0);
                end
                wid = int'(wr_id);
                exp_ready = (wid < NCH) ? (model_stored(wid) != `SRAM_DEPTH) : 1'b0;
                check_flag("wr_ready", wr_ready, exp_ready);
                rid = int'(rd_id);
                if (rid >= NCH) begin
                        check_word("rd_data", rd_data, '0);     // Out of range reads zero
                end else if (model_bvalid[rid] != 0) begin
                        check_word("rd_data", rd_data, model_q[rid][0]);
                end
        endtask

        // Model steps on the edge, outputs are compared once settled
        always @(posedge clk) begin
                if (checking) begin
                        advance_model();
                        #10;
                        compare_outputs();
                end
        end

        // ============================================================
        // Stimulus helpers, all driving right after a falling edge
        // ============================================================

        task automatic drive_idle();
                alloc_req  = 1'b0;
                alloc_size = '0;
                alloc_id   = '0;
                wr_valid   = 1'b0;
                wr_id      = '0;
                wr_data    = '0;
                drain_req  = '0;
                drain_size = '0;
                rd_pop     = 1'b0;
                rd_id      = '0;
        endtask

        task automatic write_beats(input int c, input int k);
                int sent;
                sent = 0;
                for (int n = 0; n < TIMEOUT_CYCLES && sent < k; n++) begin
                        @(negedge clk);
                        drive_idle();
                        if (model_stored(c) != `SRAM_DEPTH) begin      // Taken at the next edge
                                wr_valid = 1'b1;
                                wr_id    = chan_id_t'(c);
                                wr_data  = word_t'(rand_next());
                                sent++;
                        end
                end
                if (sent < k) report_failure($sformatf("channel %0d never accepted its writes", c));
        endtask

        task automatic fill_channel(input int c);
                for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
                        @(negedge clk);
                        drive_idle();
                        if (model_stored(c) == `SRAM_DEPTH) return;
                        wr_valid = 1'b1;
                        wr_id    = chan_id_t'(c);
                        wr_data  = word_t'(rand_next());
                end
                report_failure($sformatf("channel %0d did not fill", c));
        endtask

        task automatic drain_channel(input int c);
                for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
                        @(negedge clk);
                        drive_idle();
                        if (model_q[c].size() == 0) return;
                        rd_pop = 1'b1;                  // Pops on an empty bridge are ignored
                        rd_id  = chan_id_t'(c);
                end
                report_failure($sformatf("channel %0d did not drain", c));
        endtask

        task automatic wait_ready(input int c);
                for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
                        @(negedge clk);
                        drive_idle();
                        wr_id = chan_id_t'(c);
                        #1;
                        if (wr_ready) return;
                end
                report_failure($sformatf("wr_ready never reopened for channel %0d", c));
        endtask

        // ============================================================
        // Test sequence
        // ============================================================

        initial begin
                arst_n = 1'b0;
                drive_idle();
                repeat (10) @(negedge clk);     // Reset held 10 cycles
                arst_n   = 1'b1;
                checking = 1'b1;

                // Reset state, including every out-of-range ID
                for (int i = 0; i < 8; i++) begin
                        @(negedge clk);
                        drive_idle();
                        wr_id = chan_id_t'(i);
                        rd_id = chan_id_t'(i);
                end

                // Random interleaved traffic with credits
                for (int n = 0; n < RANDOM_CYCLES; n++) begin
                        @(negedge clk);
                        drive_idle();
                        wr_valid   = (rand_below(3) != 0);
                        wr_id      = random_id();
                        wr_data    = word_t'(rand_next());
                        rd_pop     = (rand_below(2) != 0);
                        rd_id      = random_id();
                        alloc_req  = (rand_below(8) == 0);
                        alloc_id   = chan_id_t'(rand_below(NCH));
                        alloc_size = size_t'(rand_below(8));
                        for (int c = 0; c < NCH; c++) begin
                                drain_req[c]  = (rand_below(16) == 0);
                                drain_size[c] = size_t'(rand_below(4));
                        end
                end
                for (int c = 0; c < NCH; c++) drain_channel(c);

                // Oversized allocation clamps space_free at zero
                @(negedge clk);
                drive_idle();
                alloc_req  = 1'b1;
                alloc_id   = chan_id_t'(3);
                alloc_size = size_t'(20);
                write_beats(3, 5);
                drain_channel(3);

                // Back-pressure on one full channel while another accepts
                fill_channel(0);
                for (int n = 0; n < 3; n++) begin
                        @(negedge clk);
                        drive_idle();
                        wr_valid = 1'b1;
                        wr_id    = chan_id_t'(0);
                        wr_data  = word_t'(rand_next());
                end
                write_beats(1, 1);
                @(negedge clk);
                drive_idle();
                rd_pop = 1'b1;
                rd_id  = chan_id_t'(0);
                wait_ready(0);
                drain_channel(0);
                drain_channel(1);

                // Drain reservations net off available data
                write_beats(2, 6);
                @(negedge clk);
                drive_idle();
                drain_req[2]  = 1'b1;
                drain_size[2] = size_t'(4);
                drain_channel(2);

                // Out-of-range IDs touch nothing
                for (int k = 0; k < 4; k++) begin
                        @(negedge clk);
                        drive_idle();
                        wr_valid   = 1'b1;
                        wr_id      = chan_id_t'(4 + k);
                        wr_data    = word_t'(rand_next());
                        rd_pop     = 1'b1;
                        rd_id      = chan_id_t'(7 - k);
                        alloc_req  = 1'b1;
                        alloc_id   = chan_id_t'(5);
                        alloc_size = size_t'(9);
                end

                @(negedge clk);
                drive_idle();
                repeat (4) @(negedge clk);
                $display("All tests passed");
                $finish;
        end

endmodule : tb_sram_controller

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/sram_ctrl_pkg.sv
hdl/chan_port_if.sv
hdl/chan_id_decode.sv
hdl/sram_channel_unit.sv
hdl/chan_latency_bridge.sv
hdl/sram_controller.sv
tb/tb_sram_controller.sv

/* run.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator
# A $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing -j 0 \
        -f project.f \
        --top-module tb_sram_controller \
        -o tb_sram_controller

./obj_dir/tb_sram_controller
